/* logic/clock_ctrl_pkg.sv */
`default_nettype none

//------------------------------
// Clock control shared definitions
//------------------------------
package clock_ctrl_pkg;

	localparam int n_dps           = 9;    // 2 ALCT + 7 DCFEB phase shifters
	localparam int n_raw_clk       = 7;    // Unused clock inputs under pseudo-lock watch
	localparam int steps_per_cycle = 1400; // Fine PLL steps in one clock period

	typedef logic [7:0]  req_t;            // Phase request, 0-255
	typedef logic [10:0] step_t;           // Phase in fine steps, 0-1399

	localparam int req_levels = 1 << $bits(req_t); // Request codes per period

	// Phaser FSM, also exported as the state vector
	typedef enum logic [2:0] {
		idle,                              // Waiting for a fire
		wait_lock,                         // Holding until both PLLs lock
		step,                              // Compare, issue psen if not there yet
		wait_done,                         // psen out, waiting on psdone
		settle                             // Final cycle before idle
	} phaser_state_t;

	// Request to fine steps, rounded to nearest
	function automatic step_t to_steps(input req_t req);
		logic [19:0] scaled;                                   // 255*1400+128 fits in 20 bits
		scaled = 20'(req) * 20'(steps_per_cycle) + 20'(req_levels / 2);
		return step_t'(scaled / 20'(req_levels));
	endfunction

endpackage

`default_nettype wire

/* logic/phase_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

//------------------------------
// Per-channel phase commands
//------------------------------
interface phase_cmd_if;
	import clock_ctrl_pkg::*;

	logic [n_dps-1:0] fire;     // One-cycle set-phase strobe
	logic [n_dps-1:0] reset;    // One-cycle phase-to-zero strobe
	step_t            target [n_dps]; // Held target in fine steps
	logic [n_dps-1:0] busy;     // Phaser working on a command

	// Command register side
	modport source (
		output fire,
		output reset,
		output target,
		input  busy
	);

	// Phaser side
	modport sink (
		input  fire,
		input  reset,
		input  target,
		output busy
	);

endinterface

`default_nettype wire

/* logic/phase_cmd_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module phase_cmd_reg (
	input  logic                                clock,
	input  logic                                rst,
	input  logic [clock_ctrl_pkg::n_dps-1:0]    dps_fire,  // Set new phase
	input  logic [clock_ctrl_pkg::n_dps-1:0]    dps_reset, // Zero current phase
	input  logic [clock_ctrl_pkg::n_dps*$bits(clock_ctrl_pkg::req_t)-1:0] dps_phase,
	phase_cmd_if.source                         cmd
);
	import clock_ctrl_pkg::*;

	localparam int req_w = $bits(req_t); // Slice width in dps_phase

	logic [n_dps-1:0] accept;            // Fire taken this cycle

	//------------------------------
	// Fire acceptance
	//------------------------------
	// A fire already in flight counts as busy, busy only rises a cycle later
	assign accept = dps_fire & ~cmd.busy & ~cmd.fire;

	//------------------------------
	// Strobe registers
	//------------------------------
	always_ff @(posedge clock) begin
		if (rst) begin
			cmd.fire  <= '0;                 // No stale strobes out of reset
			cmd.reset <= '0;
		end else begin
			cmd.fire  <= accept;             // One cycle after the VME strobe
			cmd.reset <= dps_reset;          // Passed straight through a flop
		end
	end

	//------------------------------
	// Target translation
	//------------------------------
	always_ff @(posedge clock) begin
		for (int i = 0; i < n_dps; i++) begin
			if (accept[i]) begin
				cmd.target[i] <= to_steps(dps_phase[i*req_w +: req_w]); // 0-255 to 0-1399
			end
		end
	end

endmodule

`default_nettype wire

/* logic/phaser.sv */
`timescale 1ns/1ps
`default_nettype none

module phaser (
	input  logic                          clock,
	input  logic                          global_reset, // Held until main PLL locks
	input  logic                          lock_main,    // Main PLL lock
	input  logic                          lock_dcm,     // This channel's PLL lock
	input  logic                          fire,         // Start stepping toward target
	input  logic                          reset,        // Forget phase, back to 0
	input  clock_ctrl_pkg::step_t         target,       // Wanted phase, 0-1399
	input  logic                          psdone,       // PLL finished one step
	output logic                          psen,         // Step request to PLL
	output logic                          psincdec,     // 1 = step up, 0 = step down
	output logic                          busy,         // Command in progress
	output clock_ctrl_pkg::phaser_state_t sm_vec        // Machine state for readback
);
	import clock_ctrl_pkg::*;

	phaser_state_t state;      // FSM state
	step_t         phase;      // Current phase in fine steps
	logic          locked;     // Both PLLs usable
	logic          at_target;  // Nothing left to do
	logic          go_up;      // Target lies above current phase

	//------------------------------
	// Compare
	//------------------------------
	assign locked    = lock_main & lock_dcm;
	assign at_target = (phase == target);
	assign go_up     = (target > phase);

	//------------------------------
	// Phase shifter FSM
	//------------------------------
	always_ff @(posedge clock) begin
		if (global_reset || reset) begin
			state <= idle;                   // Abandon any step in progress
			phase <= '0;                     // PLL restarts at zero offset
		end else begin
			case (state)
				idle: begin
					if (fire) begin
						state <= step;       // Check target first
					end
				end

				wait_lock: begin
					if (locked) begin
						state <= step;
					end
				end

				step: begin
					if (at_target) begin
						state <= settle;     // Done, or nothing to do
					end else if (locked) begin
						state <= wait_done;  // psen goes out this cycle
					end else begin
						state <= wait_lock;  // Lost a lock, hold off
					end
				end

				wait_done: begin
					if (psdone) begin
						// Target is held still while busy, so the direction is unchanged
						if (go_up) begin
							phase <= phase + step_t'(1);
						end else begin
							phase <= phase - step_t'(1);
						end
						state <= step;       // Next psen a cycle after psdone
					end
				end

				settle: begin
					state <= idle;
				end

				default: begin
					state <= idle;           // Unused codes fall back
				end
			endcase
		end
	end

	//------------------------------
	// Outputs
	//------------------------------
	assign psen     = (state == step) & ~at_target & locked; // Single cycle, state moves on
	assign psincdec = (state == step) & go_up;               // Only meaningful with psen
	assign busy     = (state != idle);
	assign sm_vec   = state;

endmodule

`default_nettype wire

/* logic/reset_lock_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module reset_lock_ctrl (
	input  logic                                 clock,
	input  logic                                 rst,
	input  logic                                 lock_main,           // Main PLL lock
	input  logic                                 global_reset_en,     // Re-fire on lock loss
	input  logic [clock_ctrl_pkg::n_raw_clk-1:0] raw_clk,             // Unused clock inputs
	output logic                                 global_reset,        // Design-wide reset
	output logic                                 clock_lock_lost_err, // Main lock gone
	output logic [clock_ctrl_pkg::n_raw_clk-1:0] raw_clk_lock         // Pseudo-lock per input
);
	import clock_ctrl_pkg::*;

	logic                 startup_done; // Main PLL has locked at least once
	logic                 first_lock;   // Lock now or earlier
	logic [n_raw_clk-1:0] raw_pos_q;    // Sampled on rising edge
	logic [n_raw_clk-1:0] raw_neg_q;    // Sampled on falling edge

	//------------------------------
	// Global reset
	//------------------------------
	assign first_lock = lock_main | startup_done;

	always_ff @(posedge clock) begin
		if (rst) begin
			startup_done <= 1'b0;
			global_reset <= 1'b1;                                   // Held through rst
		end else begin
			startup_done <= first_lock;                             // Sticks on first lock
			global_reset <= ~first_lock | (~lock_main & global_reset_en); // Re-fires on loss
		end
	end

	// Loss of lock with no reset to cover it
	assign clock_lock_lost_err = ~global_reset & ~lock_main;

	//------------------------------
	// Pseudo-lock detectors
	//------------------------------
	always_ff @(posedge clock) begin
		raw_pos_q <= raw_clk;           // Rising edge sample
	end

	always_ff @(negedge clock) begin
		raw_neg_q <= raw_clk;           // Falling edge sample
	end

	// A running clock differs between the two halves of the period
	assign raw_clk_lock = raw_pos_q ^ raw_neg_q;

endmodule

`default_nettype wire

/* logic/clock_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_ctrl (
	input  logic                                 clock,
	input  logic                                 rst,
	input  logic [clock_ctrl_pkg::n_dps-1:0]     dps_fire,    // Set new phase
	input  logic [clock_ctrl_pkg::n_dps-1:0]     dps_reset,   // Zero current phase
	input  logic [clock_ctrl_pkg::n_dps*$bits(clock_ctrl_pkg::req_t)-1:0] dps_phase,
	output logic [clock_ctrl_pkg::n_dps-1:0]     dps_busy,    // Phaser working
	output logic [clock_ctrl_pkg::n_dps*$bits(clock_ctrl_pkg::phaser_state_t)-1:0] dps_sm_vec,
	input  logic [clock_ctrl_pkg::n_dps-1:0]     dps_lock,    // Channel PLL locks
	output logic [clock_ctrl_pkg::n_dps-1:0]     psen,        // To channel PLLs
	output logic [clock_ctrl_pkg::n_dps-1:0]     psincdec,    // To channel PLLs
	input  logic [clock_ctrl_pkg::n_dps-1:0]     psdone,      // From channel PLLs
	input  logic                                 lock_main,   // Main PLL lock
	input  logic                                 global_reset_en,
	input  logic [clock_ctrl_pkg::n_raw_clk-1:0] raw_clk,
	output logic                                 global_reset,
	output logic                                 clock_lock_lost_err,
	output logic [clock_ctrl_pkg::n_raw_clk-1:0] raw_clk_lock
);
	import clock_ctrl_pkg::*;

	localparam int sm_w = $bits(phaser_state_t); // State code width per channel

	phase_cmd_if cmd_if ();                       // Commands to the phasers

	//------------------------------
	// Command register
	//------------------------------
	phase_cmd_reg i_phase_cmd_reg (
		.clock     (clock),
		.rst       (rst),
		.dps_fire  (dps_fire),
		.dps_reset (dps_reset),
		.dps_phase (dps_phase),
		.cmd       (cmd_if.source)
	);

	//------------------------------
	// Phaser array
	//------------------------------
	for (genvar g = 0; g < n_dps; g++) begin : g_dps
		phaser i_phaser (
			.clock        (clock),
			.global_reset (global_reset),         // Internal reset, not rst
			.lock_main    (lock_main),
			.lock_dcm     (dps_lock[g]),
			.fire         (cmd_if.fire[g]),
			.reset        (cmd_if.reset[g]),
			.target       (cmd_if.target[g]),
			.psdone       (psdone[g]),
			.psen         (psen[g]),
			.psincdec     (psincdec[g]),
			.busy         (cmd_if.busy[g]),
			.sm_vec       (dps_sm_vec[g*sm_w +: sm_w])
		);
	end

	assign dps_busy = cmd_if.busy;                // Busy also read back by command side

	//------------------------------
	// Reset and lock status
	//------------------------------
	reset_lock_ctrl i_reset_lock_ctrl (
		.clock               (clock),
		.rst                 (rst),
		.lock_main           (lock_main),
		.global_reset_en     (global_reset_en),
		.raw_clk             (raw_clk),
		.global_reset        (global_reset),
		.clock_lock_lost_err (clock_lock_lost_err),
		.raw_clk_lock        (raw_clk_lock)
	);

endmodule

`default_nettype wire

/* dv/clock_ctrl_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_ctrl_properties (
	input logic clock,
	input logic global_reset,
	input logic reset,        // Channel phase-to-zero strobe
	input logic psen,
	input logic psdone,
	input logic busy
);

	logic pending;            // psen out, psdone not back yet

	always_ff @(posedge clock) begin
		if (global_reset || reset) begin
			pending <= 1'b0;      // Step abandoned
		end else begin
			if (psdone) pending <= 1'b0;
			if (psen) pending <= 1'b1;
		end
	end

	//------------------------------
	// Handshake
	//------------------------------
	a_psen_single: assert property (@(posedge clock) disable iff (global_reset)
		psen |=> !psen)
		else $error("psen held for more than one cycle");

	a_psen_waits: assert property (@(posedge clock) disable iff (global_reset)
		pending |-> !psen)
		else $error("psen issued before psdone of the previous step");

	// Quiet once reset has been in effect for a full cycle
	a_reset_quiet: assert property (@(posedge clock)
		global_reset && $past(global_reset) |-> !psen && !busy)
		else $error("phaser active during global reset");

endmodule

bind phaser clock_ctrl_properties i_properties (
	.clock        (clock),
	.global_reset (global_reset),
	.reset        (reset),
	.psen         (psen),
	.psdone       (psdone),
	.busy         (busy)
);

`default_nettype wire

/* dv/clock_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_ctrl_tb;
	import clock_ctrl_pkg::*;

	localparam int     clk_period  = 8;                    // ns
	localparam int     n_cmds      = 40;                   // Random fire commands
	localparam int     req_w       = $bits(req_t);
	localparam int     sm_w        = $bits(phaser_state_t);
	localparam int     step_limit  = steps_per_cycle * 16; // Cycles allowed per command
	localparam longint watchdog_ns = longint'(n_cmds) * steps_per_cycle * 8 * clk_period + 200000;
	localparam logic [n_raw_clk-1:0] raw_expected = n_raw_clk'(3); // Two running inputs

	logic                       clock;
	logic                       rst;
	logic [n_dps-1:0]           dps_fire;
	logic [n_dps-1:0]           dps_reset;
	logic [n_dps*req_w-1:0]     dps_phase;
	logic [n_dps-1:0]           dps_busy;
	logic [n_dps*sm_w-1:0]      dps_sm_vec;
	logic [n_dps-1:0]           dps_lock = '1;         // Owned by the PLL model
	logic [n_dps-1:0]           psen;
	logic [n_dps-1:0]           psincdec;
	logic [n_dps-1:0]           psdone = '0;           // Owned by the PLL model
	logic [n_dps-1:0]           psen_seen = '0;        // psen as taken at the last rising edge
	logic [n_dps-1:0]           dir_seen = '0;         // psincdec at that same edge
	logic                       lock_main;
	logic                       global_reset_en;
	logic [n_raw_clk-1:0]       raw_clk;
	logic                       global_reset;
	logic                       clock_lock_lost_err;
	logic [n_raw_clk-1:0]       raw_clk_lock;
	logic                       delayed_clk;
	logic                       lock_jitter;           // Drop channel locks at random

	integer seed       = 10969;                        // Stimulus
	integer pll_seed   = 10969;                        // PLL model delays and locks
	int     errors     = 0;
	int     checks     = 0;
	int     model_step [n_dps];                        // Reference phase per channel
	int     net_steps  [n_dps] = '{default: 0};        // Up minus down psen
	int     done_cnt   [n_dps] = '{default: 0};        // Cycles left to psdone

	clock_ctrl i_dut (
		.clock (clock), .rst (rst),
		.dps_fire (dps_fire), .dps_reset (dps_reset), .dps_phase (dps_phase),
		.dps_busy (dps_busy), .dps_sm_vec (dps_sm_vec), .dps_lock (dps_lock),
		.psen (psen), .psincdec (psincdec), .psdone (psdone),
		.lock_main (lock_main), .global_reset_en (global_reset_en), .raw_clk (raw_clk),
		.global_reset (global_reset), .clock_lock_lost_err (clock_lock_lost_err),
		.raw_clk_lock (raw_clk_lock)
	);

	initial begin
		clock = 1'b0;
		forever #(clk_period / 2) clock = ~clock;
	end

	assign #2 delayed_clk = clock;                     // Running clock 2 ns late
	assign raw_clk = {1'b1, {(n_raw_clk - 3){1'b0}}, ~delayed_clk, delayed_clk};

	//------------------------------
	// PLL model
	//------------------------------
	// psen depends on the locks, so take it at the edge where the DUT acts on it
	always @(posedge clock) begin
		psen_seen <= psen;
		dir_seen  <= psincdec;
	end

	always @(negedge clock) begin
		for (int i = 0; i < n_dps; i++) begin
			psdone[i] = 1'b0;                            // One-cycle strobe
			if (psen_seen[i]) begin
				net_steps[i] += dir_seen[i] ? 1 : -1;
				done_cnt[i] = 1 + ($unsigned($random(pll_seed)) % 8); // psdone 1-8 cycles on
			end
			if (done_cnt[i] > 0) begin
				done_cnt[i]--;
				if (done_cnt[i] == 0) psdone[i] = 1'b1;
			end
			dps_lock[i] = lock_jitter ? (($random(pll_seed) & 7) != 0) : 1'b1;
		end
	end

	task automatic report_error(input string msg);
		errors++;
		$display("** Error at %0t ns: %s", $time, msg);
	endtask

	// Nearest fine step for a 0-255 request
	function automatic int expected_steps(input int req);
		return (req * steps_per_cycle + 128) / 256;
	endfunction

	task automatic wait_busy(input int ch, input logic level, input int limit, output bit ok);
		ok = 1'b0;
		for (int n = 0; n < limit && !ok; n++) begin
			@(negedge clock);
			ok = (dps_busy[ch] == level);
		end
	endtask

	task automatic wait_global_reset(input logic level, input int limit, output bit ok);
		ok = 1'b0;
		for (int n = 0; n < limit && !ok; n++) begin
			@(negedge clock);
			ok = (global_reset == level);
		end
	endtask

	task automatic zero_channel(input int ch);
		dps_reset[ch] = 1'b1;
		@(negedge clock);
		dps_reset[ch] = 1'b0;
		repeat (2) @(negedge clock);                   // Register stage and then phaser
		model_step[ch] = 0;
	endtask

	// Fire one request and optionally a second one while busy
	task automatic run_fire(input int ch, input req_t req, input bit extra);
		int exp_step;
		int start_net;
		bit ok;
		exp_step  = expected_steps(int'(req));
		start_net = net_steps[ch];
		dps_phase[ch*req_w +: req_w] = req;
		dps_fire[ch] = 1'b1;
		@(negedge clock);
		dps_fire[ch] = 1'b0;
		wait_busy(ch, 1'b1, 8, ok);
		if (!ok) begin
			errors++;
			$display("Channel %0d never went busy after a fire", ch);
			return;
		end
		if (extra) begin
			dps_phase[ch*req_w +: req_w] = ~req;         // Must be dropped
			dps_fire[ch] = 1'b1;
			@(negedge clock);
			dps_fire[ch] = 1'b0;
		end
		wait_busy(ch, 1'b0, step_limit, ok);
		if (!ok) begin
			errors++;
			$display("Channel %0d stayed busy too long", ch);
			return;
		end
		checks++;
		if (net_steps[ch] - start_net != exp_step - model_step[ch])
			report_error($sformatf("ch %0d req %0d: net steps %0d, expected %0d", ch, req,
				net_steps[ch] - start_net, exp_step - model_step[ch]));
		checks++;
		if (dps_sm_vec[ch*sm_w +: sm_w] != idle)
			report_error($sformatf("ch %0d not idle after busy fell", ch));
		model_step[ch] = exp_step;
	endtask

	//------------------------------
	// Stimulus and checks
	//------------------------------
	initial begin
		bit   ok;
		int   ch;
		req_t req;
		rst = 1'b1;
		dps_fire = '0;
		dps_reset = '0;
		dps_phase = '0;
		lock_main = 1'b0;
		global_reset_en = 1'b0;
		lock_jitter = 1'b0;
		for (int i = 0; i < n_dps; i++) model_step[i] = 0;

		// Reset phase with lock_main still low
		for (int n = 0; n < 14; n++) begin
			@(negedge clock);
			if (n == 7) rst = 1'b0;
			checks++;
			if (global_reset !== 1'b1 || psen !== '0 || psincdec !== '0 || dps_busy !== '0 ||
				dps_sm_vec !== {n_dps{idle}})
				report_error("global_reset low or phasers active before first lock");
		end
		lock_main = 1'b1;
		wait_global_reset(1'b0, 4, ok);
		if (!ok) begin
			errors++;
			$display("global_reset did not fall after lock_main came up");
		end

		// Random fires with some while busy and some after a channel reset
		lock_jitter = 1'b1;
		for (int k = 0; k < n_cmds; k++) begin
			ch  = $unsigned($random(seed)) % n_dps;
			req = req_t'($random(seed));
			if (k % 5 == 4) zero_channel(ch);
			run_fire(ch, req, (k % 3) == 1);
			if (k % 7 == 6) run_fire(ch, req, 1'b0);    // Already there so no steps
		end
		lock_jitter = 1'b0;

		// Loss of lock with re-fire enabled
		global_reset_en = 1'b1;
		lock_main = 1'b0;
		wait_global_reset(1'b1, 4, ok);
		if (!ok) begin
			errors++;
			$display("global_reset did not re-fire after lock_main dropped");
		end
		lock_main = 1'b1;
		wait_global_reset(1'b0, 4, ok);
		if (!ok) begin
			errors++;
			$display("global_reset stuck high after lock_main returned");
		end
		for (int i = 0; i < n_dps; i++) model_step[i] = 0; // Phases restart at 0
		run_fire(3, req_t'($random(seed)), 1'b0);

		// Loss of lock with re-fire disabled
		global_reset_en = 1'b0;
		lock_main = 1'b0;
		@(negedge clock);
		checks++;
		if (clock_lock_lost_err !== 1'b1 || global_reset !== 1'b0)
			report_error("lock loss not flagged with re-fire disabled");
		lock_main = 1'b1;
		@(negedge clock);
		checks++;
		if (clock_lock_lost_err !== 1'b0) report_error("lock-lost flag stuck high");

		// Pseudo-lock sampled clear of both edges
		repeat (4) begin
			@(posedge clock);
			#2;
			checks++;
			if (raw_clk_lock !== raw_expected)
				report_error($sformatf("raw_clk_lock %b, expected %b", raw_clk_lock, raw_expected));
		end

		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(watchdog_ns);
		$display("Watchdog expired after %0d ns, the test did not finish", watchdog_ns);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
logic/clock_ctrl_pkg.sv
logic/phase_cmd_if.sv
logic/phase_cmd_reg.sv
logic/phaser.sv
logic/reset_lock_ctrl.sv
logic/clock_ctrl.sv
dv/clock_ctrl_properties.sv
dv/clock_ctrl_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := clock_ctrl_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
